// ==== compile.f ====
rtl/net_pkg.sv
rtl/pkt_buf_if.sv
rtl/pkt_buffer.sv
rtl/key_mask_gen.sv
rtl/net_host_ctrl.sv
rtl/net_host_top.sv
sim/net_host_chk.sv
sim/net_host_tb.sv

// ==== rtl/key_mask_gen.sv ====
/* Key register and payload mask. The key advances only on advance, mixing in
   the sent destination; mask follows the key with no register stage. */
module key_mask_gen (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          advance,
    input  net_pkg::dest_t                adv_dest,
    output logic [net_pkg::payload_w-1:0] mask
);

    localparam int key_w = net_pkg::key_w;
    localparam int dest_w = net_pkg::dest_w;
    localparam int half_w = net_pkg::payload_w;

    logic [key_w-1:0] key;
    logic [dest_w-1:0] feedback;

    // Old top nibble folded with the destination of the sent packet
    assign feedback = key[key_w-1 -: dest_w] ^ adv_dest;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key <= net_pkg::key_seed;
        end else if (advance) begin
            key <= {key[key_w-dest_w-1:0], feedback};  // Shift up one nibble
        end
    end

    // Upper half folded onto lower half
    assign mask = key[key_w-1 -: half_w] ^ key[half_w-1:0];

endmodule

// ==== rtl/net_host_ctrl.sv ====
/* Admission on the write side plus the IDLE, PROCESS, SEND machine.
   One packet leaves every three cycles; packets seen while full are dropped. */
module net_host_ctrl #(
    parameter int buf_depth = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  net_pkg::pkt_word_u            packet_in,
    input  logic                          packet_valid,
    input  net_pkg::dest_t                dest_addr,
    input  logic [net_pkg::payload_w-1:0] mask,
    pkt_buf_if.access                     bus,
    output logic                          advance,
    output net_pkg::dest_t                adv_dest,
    output net_pkg::pkt_word_u            packet_out,
    output logic                          packet_ready,
    output logic                          route_error
);

    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_process = 2'd1;
    localparam logic [1:0] st_send    = 2'd2;

    logic [1:0] state;
    logic sending;
    net_pkg::pkt_word_u sent_word;

    // Pointer wrap in the buffer relies on this
    if (buf_depth < 2 || (buf_depth & (buf_depth - 1)) != 0) begin : g_depth_check
        $error("buf_depth must be a power of two of 2 or more");
    end

    // Write side runs on its own, in any state
    assign bus.push      = packet_valid && !bus.full;
    assign bus.push_pkt  = packet_in;
    assign bus.push_dest = dest_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            route_error <= 1'b0;
        end else begin
            route_error <= packet_valid && bus.full;  // Dropped packet
        end
    end

    // Pop edge is the edge that leaves SEND
    assign sending  = (state == st_send);
    assign bus.pop  = sending;
    assign advance  = sending;
    assign adv_dest = bus.head_dest;  // Key takes the destination of the sent packet

    // Header kept as stored, payload masked with the current key
    always_comb begin
        sent_word.fields.hdr     = bus.head_pkt.fields.hdr;
        sent_word.fields.payload = bus.head_pkt.fields.payload ^ mask;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (!bus.empty) begin
                        state <= st_process;
                    end
                end
                st_process: state <= st_send;
                st_send:    state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    // Output register, loaded only at the pop edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            packet_out   <= '0;
            packet_ready <= 1'b0;
        end else begin
            packet_ready <= sending;  // One cycle, since SEND never repeats
            if (sending) begin
                packet_out <= sent_word;
            end
        end
    end

endmodule

// ==== rtl/net_host_top.sv ====
/* Network host top level. No back-pressure on the output; overflow is
   handled only by dropping the packet and raising route_error. */
module net_host_top #(
    parameter int buf_depth = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [net_pkg::pkt_w-1:0]   packet_in,
    input  logic                        packet_valid,
    input  logic [net_pkg::dest_w-1:0]  dest_addr,
    output logic [net_pkg::pkt_w-1:0]   packet_out,
    output logic                        packet_ready,
    output logic                        route_error
);

    logic                          advance;
    net_pkg::dest_t                adv_dest;
    logic [net_pkg::payload_w-1:0] mask;

    pkt_buf_if #(.buf_depth(buf_depth)) buf_bus ();

    pkt_buffer #(.buf_depth(buf_depth)) u_buffer (
        .clk (clk),
        .rst (rst),
        .bus (buf_bus.store)
    );

    key_mask_gen u_key (
        .clk      (clk),
        .rst      (rst),
        .advance  (advance),
        .adv_dest (adv_dest),
        .mask     (mask)
    );

    net_host_ctrl #(.buf_depth(buf_depth)) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .packet_in    (packet_in),
        .packet_valid (packet_valid),
        .dest_addr    (dest_addr),
        .mask         (mask),
        .bus          (buf_bus.access),
        .advance      (advance),
        .adv_dest     (adv_dest),
        .packet_out   (packet_out),
        .packet_ready (packet_ready),
        .route_error  (route_error)
    );

endmodule

// ==== rtl/net_pkg.sv ====
/* Packet layout is fixed at 12 bytes with the payload in the low 64 bits.
   The key must stay twice the payload width for the mask rule. */
package net_pkg;

    localparam int pkt_bytes = 12;
    localparam int pkt_w = pkt_bytes * 8;
    localparam int payload_w = 64;
    localparam int hdr_w = pkt_w - payload_w;  // 32 bits of header
    localparam int dest_w = 4;
    localparam int key_w = 128;

    // Key value loaded at reset
    localparam logic [key_w-1:0] key_seed = 128'h3c6e_f372_a54f_f53a_510e_527f_9b05_688c;

    typedef logic [dest_w-1:0] dest_t;

    // Same word seen as raw bits or as header plus payload
    typedef union packed {
        logic [pkt_w-1:0] raw;
        struct packed {
            logic [hdr_w-1:0]     hdr;      // Passed through unchanged
            logic [payload_w-1:0] payload;  // Masked on the way out
        } fields;
    } pkt_word_u;

endpackage

// ==== rtl/pkt_buf_if.sv ====
/* Link between packet buffer and controller. Push only while full is low,
   pop only while empty is low; head entry is valid whenever empty is low. */
interface pkt_buf_if #(
    parameter int buf_depth = 4
);

    // Write side, from the controller
    logic               push;
    net_pkg::pkt_word_u push_pkt;
    net_pkg::dest_t     push_dest;

    logic               pop;        // Read side, from the controller

    // Head of queue and status, from the buffer
    net_pkg::pkt_word_u head_pkt;
    net_pkg::dest_t     head_dest;
    logic               full;
    logic               empty;
    logic [$clog2(buf_depth):0] count;  // Occupancy, owned by the buffer

    modport store (
        input  push, push_pkt, push_dest, pop,
        output head_pkt, head_dest, full, empty, count
    );

    modport access (
        output push, push_pkt, push_dest, pop,
        input  head_pkt, head_dest, full, empty
    );

endinterface

// ==== rtl/pkt_buffer.sv ====
/* Circular packet queue, buf_depth a power of two of 2 or more.
   Push and pop in the same cycle leave the count unchanged. */
module pkt_buffer #(
    parameter int buf_depth = 4
) (
    input logic      clk,
    input logic      rst,
    pkt_buf_if.store bus
);

    localparam int idx_w = $clog2(buf_depth);
    localparam int cnt_w = idx_w + 1;

    net_pkg::pkt_word_u pkt_mem [buf_depth];
    net_pkg::dest_t     dest_mem [buf_depth];

    logic [idx_w-1:0] head;  // Oldest entry
    logic [idx_w-1:0] tail;  // Next free slot

    // Storage, written at the tail
    always_ff @(posedge clk) begin
        if (bus.push) begin
            pkt_mem[tail]  <= bus.push_pkt;
            dest_mem[tail] <= bus.push_dest;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            bus.count <= '0;
        end else begin
            if (bus.push) begin
                tail <= tail + 1'b1;  // Wraps on its own
            end
            if (bus.pop) begin
                head <= head + 1'b1;
            end
            case ({bus.push, bus.pop})
                2'b10:   bus.count <= bus.count + 1'b1;
                2'b01:   bus.count <= bus.count - 1'b1;
                default: bus.count <= bus.count;  // Idle, or push and pop together
            endcase
        end
    end

    assign bus.full  = (bus.count == cnt_w'(buf_depth));
    assign bus.empty = (bus.count == '0);

    // Head presented without a register stage
    assign bus.head_pkt  = pkt_mem[head];
    assign bus.head_dest = dest_mem[head];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it, and decides pass or fail from the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir build.log "$log"

verilator --binary --timing --assert -f compile.f --top-module net_host_tb \
    -o sim_net_host > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_net_host > "$log" 2>&1 || true
cat "$log"

grep -q "^Simulation PASSED$" "$log" && echo "result: pass" && exit 0 \
    || { echo "result: fail"; exit 1; }

// ==== sim/net_host_chk.sv ====
/* Protocol checks on net_host_ctrl, attached with bind. Checks are off during reset. */
module net_host_chk (
    input logic clk,
    input logic rst,
    input logic packet_valid,
    input logic full,
    input logic empty,
    input logic push,
    input logic pop,
    input logic packet_ready,
    input logic route_error
);

    a_ready_one_cycle: assert property (@(posedge clk) disable iff (rst)
        packet_ready |=> !packet_ready)
        else $error("packet_ready high for two cycles in a row");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
        else $error("pop while the buffer is empty");

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("push while the buffer is full");

    // Flag only follows a packet offered while full
    a_error_after_drop: assert property (@(posedge clk) disable iff (rst)
        route_error |-> $past(packet_valid && full))
        else $error("route_error without a dropped packet the cycle before");

endmodule

bind net_host_ctrl net_host_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .packet_valid (packet_valid),
    .full         (bus.full),
    .empty        (bus.empty),
    .push         (bus.push),
    .pop          (bus.pop),
    .packet_ready (packet_ready),
    .route_error  (route_error)
);

// ==== sim/net_host_tb.sv ====
/* Directed testbench for net_host_top with buf_depth 4. Drops are taken from
   route_error; every other offered packet must come out in order and masked. */
module net_host_tb;

    localparam int timeout_cycles = 200;

    logic                       clk = 1'b0;
    logic                       rst = 1'b1;
    logic [net_pkg::pkt_w-1:0]  packet_in;
    logic                       packet_valid;
    logic [net_pkg::dest_w-1:0] dest_addr;
    logic [net_pkg::pkt_w-1:0]  packet_out;
    logic                       packet_ready;
    logic                       route_error;

    integer seed = 32'h874c_dee3;

    // Reference model
    net_pkg::pkt_word_u        exp_pkt_q[$];
    net_pkg::dest_t            exp_dest_q[$];
    logic [net_pkg::key_w-1:0] model_key;
    logic                      prev_valid;
    net_pkg::pkt_word_u        prev_pkt;
    net_pkg::dest_t            prev_dest;
    int offered_count = 0;
    int sent_count = 0;
    int flagged_count = 0;

    net_host_top #(.buf_depth(4)) UUT (
        .clk          (clk),
        .rst          (rst),
        .packet_in    (packet_in),
        .packet_valid (packet_valid),
        .dest_addr    (dest_addr),
        .packet_out   (packet_out),
        .packet_ready (packet_ready),
        .route_error  (route_error)
    );

    always #5 clk = ~clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // Upper key half XOR lower key half
    function automatic logic [net_pkg::payload_w-1:0] mask_of(
        input logic [net_pkg::key_w-1:0] key);
        return key[net_pkg::key_w-1:net_pkg::payload_w] ^ key[net_pkg::payload_w-1:0];
    endfunction

    // Shift up a nibble, old top nibble XOR destination enters at the bottom
    function automatic logic [net_pkg::key_w-1:0] next_key(
        input logic [net_pkg::key_w-1:0] key, input net_pkg::dest_t dest);
        return {key[net_pkg::key_w-5:0], key[net_pkg::key_w-1 -: 4] ^ dest};
    endfunction

    function automatic net_pkg::pkt_word_u random_word();
        net_pkg::pkt_word_u word;
        word.fields.hdr     = $random(seed);
        word.fields.payload = {$random(seed), $random(seed)};
        return word;
    endfunction

    function automatic net_pkg::dest_t random_dest();
        int r;
        r = $random(seed);
        return r[3:0];
    endfunction

    task automatic check_packet(input net_pkg::pkt_word_u got, input net_pkg::pkt_word_u exp);
        if (got.fields.hdr !== exp.fields.hdr) begin
            report_failure($sformatf("mismatch at %0t: packet_out.hdr expected %h got %h",
                $time, exp.fields.hdr, got.fields.hdr));
        end else if (got.fields.payload !== exp.fields.payload) begin
            report_failure($sformatf("mismatch at %0t: packet_out.payload expected %h got %h",
                $time, exp.fields.payload, got.fields.payload));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s expected %b got %b",
                $time, name, exp, got));
        end
    endtask

    // Outputs settle by the falling edge
    always @(negedge clk) begin
        net_pkg::pkt_word_u expected;
        net_pkg::dest_t     sent_dest;
        if (!rst) begin
            // Last cycle's offer was either queued or flagged
            if (route_error) begin
                if (!prev_valid) begin
                    report_failure("route_error rose with no packet offered the cycle before");
                end else begin
                    flagged_count++;
                end
            end else if (prev_valid) begin
                exp_pkt_q.push_back(prev_pkt);
                exp_dest_q.push_back(prev_dest);
            end
            if (packet_ready) begin
                if (exp_pkt_q.size() == 0) begin
                    report_failure("packet_ready pulsed with no packet left in the model");
                end else begin
                    expected = exp_pkt_q.pop_front();
                    sent_dest = exp_dest_q.pop_front();
                    expected.fields.payload = expected.fields.payload ^ mask_of(model_key);
                    check_packet(packet_out, expected);
                    model_key = next_key(model_key, sent_dest);
                    sent_count++;
                end
            end
        end
        prev_valid = packet_valid;
        prev_pkt = packet_in;
        prev_dest = dest_addr;
    end

    task automatic drive_packet(input net_pkg::pkt_word_u word, input net_pkg::dest_t dest);
        @(posedge clk);
        packet_valid <= 1'b1;
        packet_in    <= word.raw;
        dest_addr    <= dest;
        offered_count++;
    endtask

    task automatic release_input();
        @(posedge clk);  // Accepting edge of the last packet
        packet_valid <= 1'b0;
    endtask

    task automatic wait_ready(output int edges);
        bit seen;
        seen = 1'b0;
        edges = 0;
        while (!seen && edges < timeout_cycles) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            seen = packet_ready;
        end
        if (!seen) begin
            report_failure("timed out waiting for packet_ready");
        end
    endtask

    // Every offered packet is either sent or flagged
    task automatic wait_settled();
        int cycles;
        cycles = 0;
        while (sent_count + flagged_count != offered_count && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if (sent_count + flagged_count != offered_count) begin
            report_failure("timed out waiting for the offered packets to be sent or flagged");
        end
    endtask

    task automatic test_reset_quiet();
        net_pkg::pkt_word_u zero_word;
        zero_word = '0;
        repeat (10) begin
            @(negedge clk);
            check_flag("packet_ready", packet_ready, 1'b0);
            check_flag("route_error", route_error, 1'b0);
            check_packet(packet_out, zero_word);
        end
    endtask

    task automatic test_single_latency();
        int edges;
        drive_packet(random_word(), 4'h5);
        release_input();
        wait_ready(edges);
        if (edges != 3) begin
            report_failure($sformatf("mismatch at %0t: packet_ready latency expected 3 got %0d",
                $time, edges));
        end
        wait_settled();
    endtask

    task automatic test_spaced_order();
        net_pkg::dest_t dests[4];
        int flagged_before;
        dests = '{4'h1, 4'h7, 4'hA, 4'hF};
        flagged_before = flagged_count;
        foreach (dests[i]) begin
            drive_packet(random_word(), dests[i]);
            release_input();
            repeat (4) @(posedge clk);
        end
        wait_settled();
        if (flagged_count != flagged_before) begin
            report_failure("spaced packets were dropped");
        end
    endtask

    task automatic test_burst_drops();
        int flagged_before;
        flagged_before = flagged_count;
        repeat (10) drive_packet(random_word(), random_dest());
        release_input();
        wait_settled();
        if (flagged_count == flagged_before) begin
            report_failure("burst of ten packets caused no drop");
        end
    endtask

    task automatic test_zero_payload();
        net_pkg::pkt_word_u word;
        word = random_word();
        word.fields.payload = '0;  // Output payload is then the mask alone
        drive_packet(word, 4'h9);
        release_input();
        wait_settled();
    endtask

    initial begin
        packet_valid = 1'b0;
        packet_in    = '0;
        dest_addr    = '0;
        model_key    = net_pkg::key_seed;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_reset_quiet();
        test_single_latency();
        test_spaced_order();
        test_burst_drops();
        test_zero_payload();
        @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule
